// File: rtl/overlay_pkg.sv
package overlay_pkg;

    // RGB565 pixel with red in the top five bits
    typedef logic [15:0] pixel_t;

    // Unsigned screen coordinate
    typedef logic [10:0] coord_t;

    // Signed foreground coordinate and offset
    typedef logic signed [11:0] scoord_t;

    // Foreground opacity in eighths, 0 to 8
    typedef logic [3:0] opacity_t;

    // Log2 of full opacity
    localparam int OPACITY_SHIFT = 3;
    localparam opacity_t FULL_OPACITY = opacity_t'(1 << OPACITY_SHIFT);

    // Cycles from a background strobe to the matching foreground response
    localparam int FETCH_DELAY = 3;

    // Channel widths inside pixel_t
    localparam int RED_BITS   = 5;
    localparam int GREEN_BITS = 6;
    localparam int BLUE_BITS  = 5;

    // MODE_BG_ALT behaves as MODE_BG
    typedef enum logic [1:0]
    {
        MODE_BG     = 2'd0,
        MODE_CHROMA = 2'd1,
        MODE_BLEND  = 2'd2,
        MODE_BG_ALT = 2'd3
    } overlay_mode_t;

endpackage

// File: rtl/fg_request.sv
`timescale 1ns/1ps

module fg_request
    import overlay_pkg::*;
#(
    parameter int FG_WIDTH  = 32,
    parameter int FG_HEIGHT = 16,
    localparam int ADDR_W   = $clog2(FG_WIDTH * FG_HEIGHT)
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              bg_valid,
    input  logic              bg_blank,
    input  coord_t            bg_x,
    input  coord_t            bg_y,
    input  logic [1:0]        fg_scale,
    input  scoord_t           fg_offset_x,
    input  scoord_t           fg_offset_y,
    input  coord_t            clip_left,
    input  coord_t            clip_right,
    input  coord_t            clip_top,
    input  coord_t            clip_bottom,
    output logic              req_valid,
    output logic              req_active,
    output logic [ADDR_W-1:0] req_addr
);
    // One bit wider than scoord_t so the subtraction cannot wrap
    logic signed [$bits(scoord_t):0] fx;
    logic signed [$bits(scoord_t):0] fy;
    logic                            in_image;
    logic                            in_clip;
    logic [ADDR_W-1:0]               addr_next;

    // Position relative to the foreground origin, then downscaled
    assign fx = ($signed({1'b0, bg_x}) - fg_offset_x) >>> fg_scale;
    assign fy = ($signed({1'b0, bg_y}) - fg_offset_y) >>> fg_scale;

    assign in_image = !fx[$bits(scoord_t)] && !fy[$bits(scoord_t)]
                   && (fx < FG_WIDTH) && (fy < FG_HEIGHT);

    assign in_clip = (bg_x >= clip_left) && (bg_x <= clip_right)
                  && (bg_y >= clip_top) && (bg_y <= clip_bottom);

    // Only meaningful when in_image holds
    assign addr_next = ADDR_W'(fy * FG_WIDTH + fx);

    // No request for blanking pixels
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= bg_valid && !bg_blank;
        end
    end

    always_ff @(posedge clk)
    begin
        req_active <= in_image && in_clip;
        req_addr   <= addr_next;
    end

endmodule

// File: rtl/fg_store.sv
`timescale 1ns/1ps

module fg_store
    import overlay_pkg::*;
#(
    parameter int FG_WIDTH  = 32,
    parameter int FG_HEIGHT = 16,
    localparam int DEPTH    = FG_WIDTH * FG_HEIGHT,
    localparam int ADDR_W   = $clog2(DEPTH)
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  pixel_t            wr_pixel,
    input  logic              req_valid,
    input  logic              req_active,
    input  logic [ADDR_W-1:0] req_addr,
    output logic              fg_valid,
    output logic              fg_skip,
    output pixel_t            fg_pixel
);
    pixel_t mem [DEPTH];

    // RAM output stage
    logic   rd_valid;
    logic   rd_active;
    pixel_t rd_pixel;

    // Host write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // Read only for covered positions
    always_ff @(posedge clk)
    begin
        if (req_valid && req_active)
        begin
            rd_pixel <= mem[req_addr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid <= 1'b0;
            fg_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= req_valid;
            fg_valid <= rd_valid;
        end
    end

    // Output register where an uncovered position returns skip
    always_ff @(posedge clk)
    begin
        rd_active <= req_active;
        fg_skip   <= !rd_active;
        fg_pixel  <= rd_pixel;
    end

endmodule

// File: rtl/chroma_key.sv
`timescale 1ns/1ps

module chroma_key
    import overlay_pkg::*;
#(
    parameter pixel_t KEY_COLOR = 16'h07E0
)
(
    input  pixel_t bg_pixel,
    input  pixel_t fg_pixel,
    input  logic   fg_skip,
    output pixel_t key_pixel
);
    logic is_key;

    assign is_key = (fg_pixel == KEY_COLOR);

    // Background shows through uncovered or key-coloured positions
    always_comb
    begin
        if (fg_skip || is_key)
        begin
            key_pixel = bg_pixel;
        end
        else
        begin
            key_pixel = fg_pixel;
        end
    end

endmodule

// File: rtl/alpha_blend.sv
`timescale 1ns/1ps

module alpha_blend
    import overlay_pkg::*;
(
    input  pixel_t   bg_pixel,
    input  pixel_t   fg_pixel,
    input  logic     fg_skip,
    input  opacity_t opacity,
    output pixel_t   blend_pixel
);
    opacity_t               alpha;
    logic [RED_BITS-1:0]    red;
    logic [GREEN_BITS-1:0]  green;
    logic [BLUE_BITS-1:0]   blue;

    // Weighted sum of one channel
    // Narrower channels are zero extended to six bits
    function automatic logic [GREEN_BITS-1:0] mix(
        input logic [GREEN_BITS-1:0] f,
        input logic [GREEN_BITS-1:0] b,
        input opacity_t              a
    );
        logic [GREEN_BITS+OPACITY_SHIFT:0] sum;
        sum = f * a + b * (FULL_OPACITY - a);
        return sum[GREEN_BITS+OPACITY_SHIFT-1:OPACITY_SHIFT];
    endfunction

    // Anything above full opacity counts as full
    assign alpha = (opacity > FULL_OPACITY) ? FULL_OPACITY : opacity;

    assign red = RED_BITS'(mix(
        GREEN_BITS'(fg_pixel[15 -: RED_BITS]),
        GREEN_BITS'(bg_pixel[15 -: RED_BITS]),
        alpha));
    assign green = mix(
        fg_pixel[BLUE_BITS +: GREEN_BITS],
        bg_pixel[BLUE_BITS +: GREEN_BITS],
        alpha);
    assign blue = BLUE_BITS'(mix(
        GREEN_BITS'(fg_pixel[BLUE_BITS-1:0]),
        GREEN_BITS'(bg_pixel[BLUE_BITS-1:0]),
        alpha));

    assign blend_pixel = fg_skip ? bg_pixel : {red, green, blue};

endmodule

// File: rtl/overlay_pipeline.sv
`timescale 1ns/1ps

module overlay_pipeline
    import overlay_pkg::*;
#(
    parameter pixel_t KEY_COLOR = 16'h07E0
)
(
    input  logic          clk,
    input  logic          reset,
    input  logic          bg_valid,
    input  logic          bg_blank,
    input  coord_t        bg_x,
    input  coord_t        bg_y,
    input  pixel_t        bg_pixel,
    input  logic          fg_valid,
    input  logic          fg_skip,
    input  pixel_t        fg_pixel,
    input  overlay_mode_t mode,
    input  opacity_t      opacity,
    output logic          out_valid,
    output coord_t        out_x,
    output coord_t        out_y,
    output pixel_t        out_pixel
);
    // Background data waiting for the foreground response
    logic [FETCH_DELAY-1:0] dl_valid;
    logic [FETCH_DELAY-1:0] dl_blank;
    coord_t                 dl_x     [FETCH_DELAY];
    coord_t                 dl_y     [FETCH_DELAY];
    pixel_t                 dl_pixel [FETCH_DELAY];

    logic   emit;
    pixel_t key_pixel;
    pixel_t blend_pixel;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dl_valid <= '0;
        end
        else
        begin
            dl_valid <= {dl_valid[FETCH_DELAY-2:0], bg_valid};
        end
    end

    always_ff @(posedge clk)
    begin
        dl_blank    <= {dl_blank[FETCH_DELAY-2:0], bg_blank};
        dl_x[0]     <= bg_x;
        dl_y[0]     <= bg_y;
        dl_pixel[0] <= bg_pixel;
        for (int i = 1; i < FETCH_DELAY; i++)
        begin
            dl_x[i]     <= dl_x[i-1];
            dl_y[i]     <= dl_y[i-1];
            dl_pixel[i] <= dl_pixel[i-1];
        end
    end

    // Blanking pixels have no foreground response to wait for
    assign emit = dl_valid[FETCH_DELAY-1] && (dl_blank[FETCH_DELAY-1] || fg_valid);

    chroma_key #(
        .KEY_COLOR (KEY_COLOR)
    ) chroma_key_i (
        .bg_pixel  (dl_pixel[FETCH_DELAY-1]),
        .fg_pixel  (fg_pixel),
        .fg_skip   (fg_skip),
        .key_pixel (key_pixel)
    );

    alpha_blend alpha_blend_i (
        .bg_pixel    (dl_pixel[FETCH_DELAY-1]),
        .fg_pixel    (fg_pixel),
        .fg_skip     (fg_skip),
        .opacity     (opacity),
        .blend_pixel (blend_pixel)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= emit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            out_x <= dl_x[FETCH_DELAY-1];
            out_y <= dl_y[FETCH_DELAY-1];
            if (dl_blank[FETCH_DELAY-1])
            begin
                out_pixel <= '0;
            end
            else
            begin
                case (mode)
                    MODE_CHROMA: out_pixel <= key_pixel;
                    MODE_BLEND:  out_pixel <= blend_pixel;
                    // MODE_BG and MODE_BG_ALT
                    default:     out_pixel <= dl_pixel[FETCH_DELAY-1];
                endcase
            end
        end
    end

endmodule

// File: rtl/overlay_top.sv
`timescale 1ns/1ps

module overlay_top
    import overlay_pkg::*;
#(
    parameter int     FG_WIDTH  = 32,
    parameter int     FG_HEIGHT = 16,
    parameter pixel_t KEY_COLOR = 16'h07E0,
    localparam int    ADDR_W    = $clog2(FG_WIDTH * FG_HEIGHT)
)
(
    input  logic              clk,
    input  logic              reset,
    // Background stream
    input  logic              bg_valid,
    input  coord_t            bg_x,
    input  coord_t            bg_y,
    input  pixel_t            bg_pixel,
    input  logic              bg_blank,
    // Controls
    input  overlay_mode_t     mode,
    input  logic [1:0]        fg_scale,
    input  scoord_t           fg_offset_x,
    input  scoord_t           fg_offset_y,
    input  opacity_t          opacity,
    input  coord_t            clip_left,
    input  coord_t            clip_right,
    input  coord_t            clip_top,
    input  coord_t            clip_bottom,
    // Host write port
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  pixel_t            wr_pixel,
    // Output stream
    output logic              out_valid,
    output coord_t            out_x,
    output coord_t            out_y,
    output pixel_t            out_pixel
);
    logic              req_valid;
    logic              req_active;
    logic [ADDR_W-1:0] req_addr;
    logic              fg_valid;
    logic              fg_skip;
    pixel_t            fg_pixel;

    fg_request #(
        .FG_WIDTH  (FG_WIDTH),
        .FG_HEIGHT (FG_HEIGHT)
    ) fg_request_i (
        .clk         (clk),
        .reset       (reset),
        .bg_valid    (bg_valid),
        .bg_blank    (bg_blank),
        .bg_x        (bg_x),
        .bg_y        (bg_y),
        .fg_scale    (fg_scale),
        .fg_offset_x (fg_offset_x),
        .fg_offset_y (fg_offset_y),
        .clip_left   (clip_left),
        .clip_right  (clip_right),
        .clip_top    (clip_top),
        .clip_bottom (clip_bottom),
        .req_valid   (req_valid),
        .req_active  (req_active),
        .req_addr    (req_addr)
    );

    fg_store #(
        .FG_WIDTH  (FG_WIDTH),
        .FG_HEIGHT (FG_HEIGHT)
    ) fg_store_i (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_pixel   (wr_pixel),
        .req_valid  (req_valid),
        .req_active (req_active),
        .req_addr   (req_addr),
        .fg_valid   (fg_valid),
        .fg_skip    (fg_skip),
        .fg_pixel   (fg_pixel)
    );

    overlay_pipeline #(
        .KEY_COLOR (KEY_COLOR)
    ) overlay_pipeline_i (
        .clk       (clk),
        .reset     (reset),
        .bg_valid  (bg_valid),
        .bg_blank  (bg_blank),
        .bg_x      (bg_x),
        .bg_y      (bg_y),
        .bg_pixel  (bg_pixel),
        .fg_valid  (fg_valid),
        .fg_skip   (fg_skip),
        .fg_pixel  (fg_pixel),
        .mode      (mode),
        .opacity   (opacity),
        .out_valid (out_valid),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_pixel (out_pixel)
    );

endmodule

// File: test/overlay_asserts.sv
`timescale 1ns/1ps

module overlay_asserts
    import overlay_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic bg_valid,
    input logic bg_blank,
    input logic req_valid,
    input logic fg_valid,
    input logic out_valid
);

    // Every strobe comes out one cycle after the delay line
    out_timing: assert property (
        @(posedge clk) disable iff (reset)
        out_valid == $past(bg_valid, FETCH_DELAY + 1))
    else $error("out_valid did not follow bg_valid by %0d cycles", FETCH_DELAY + 1);

    // Blanking strobes make no foreground request
    req_timing: assert property (
        @(posedge clk) disable iff (reset)
        req_valid == $past(bg_valid && !bg_blank))
    else $error("req_valid does not match a non-blanking strobe one cycle earlier");

    fg_timing: assert property (
        @(posedge clk) disable iff (reset)
        fg_valid == $past(bg_valid && !bg_blank, FETCH_DELAY))
    else $error("fg_valid did not follow a non-blanking strobe by %0d cycles", FETCH_DELAY);

    reset_idle: assert property (
        @(posedge clk)
        $past(reset) |-> (!out_valid && !fg_valid && !req_valid))
    else $error("Valid outputs high right after reset");

endmodule

bind overlay_top overlay_asserts overlay_asserts_i (
    .clk       (clk),
    .reset     (reset),
    .bg_valid  (bg_valid),
    .bg_blank  (bg_blank),
    .req_valid (req_valid),
    .fg_valid  (fg_valid),
    .out_valid (out_valid)
);

// File: test/overlay_tb.sv
`timescale 1ns/1ps

module overlay_tb
    import overlay_pkg::*;
;
    localparam int     FG_WIDTH   = 32;
    localparam int     FG_HEIGHT  = 16;
    localparam int     ADDR_W     = $clog2(FG_WIDTH * FG_HEIGHT);
    localparam pixel_t KEY_COLOR  = 16'h07E0;
    localparam int     MAX_CYCLES = 4000;

    // Blanking choice for a stream
    localparam int NO_BLANK  = 0;
    localparam int ALL_BLANK = 1;
    localparam int MIX_BLANK = 2;

    logic              clk;
    logic              reset;
    logic              bg_valid;
    coord_t            bg_x;
    coord_t            bg_y;
    pixel_t            bg_pixel;
    logic              bg_blank;
    overlay_mode_t     mode;
    logic [1:0]        fg_scale;
    scoord_t           fg_offset_x;
    scoord_t           fg_offset_y;
    opacity_t          opacity;
    coord_t            clip_left;
    coord_t            clip_right;
    coord_t            clip_top;
    coord_t            clip_bottom;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_pixel;
    logic              out_valid;
    coord_t            out_x;
    coord_t            out_y;
    pixel_t            out_pixel;

    logic [31:0] lfsr_state = 32'hac4e733a;
    pixel_t      mirror [FG_WIDTH * FG_HEIGHT];
    int          cycle_count = 0;

    // Expected output stream with one entry per strobe
    coord_t exp_x     [$];
    coord_t exp_y     [$];
    pixel_t exp_pixel [$];
    string  exp_name  [$];

    opacity_t exp_opacity_list [4] = '{4'd0, 4'd3, 4'd8, 4'd12};

    overlay_top #(
        .FG_WIDTH  (FG_WIDTH),
        .FG_HEIGHT (FG_HEIGHT),
        .KEY_COLOR (KEY_COLOR)
    ) overlay_top_i (
        .clk         (clk),
        .reset       (reset),
        .bg_valid    (bg_valid),
        .bg_x        (bg_x),
        .bg_y        (bg_y),
        .bg_pixel    (bg_pixel),
        .bg_blank    (bg_blank),
        .mode        (mode),
        .fg_scale    (fg_scale),
        .fg_offset_x (fg_offset_x),
        .fg_offset_y (fg_offset_y),
        .opacity     (opacity),
        .clip_left   (clip_left),
        .clip_right  (clip_right),
        .clip_top    (clip_top),
        .clip_bottom (clip_bottom),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_pixel    (wr_pixel),
        .out_valid   (out_valid),
        .out_x       (out_x),
        .out_y       (out_y),
        .out_pixel   (out_pixel)
    );

    always #10 clk = ~clk;

    task automatic end_with_failure;
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [15:0] expected, input logic [15:0] actual);
        $display("FAILED %s: %s expected %h actual %h", name, what, expected, actual);
        end_with_failure();
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int blend_channel(input int f, input int b, input int a);
        return (f * a + b * (8 - a)) >> 3;
    endfunction

    // Reference model of one output pixel under the current controls
    function automatic pixel_t model_pixel(input coord_t x, input coord_t y,
                                           input pixel_t bg, input logic blank);
        int     fx;
        int     fy;
        int     alpha;
        logic   covered;
        pixel_t fg;
        fx = (int'(x) - int'(fg_offset_x)) >>> fg_scale;
        fy = (int'(y) - int'(fg_offset_y)) >>> fg_scale;
        covered = (fx >= 0) && (fy >= 0) && (fx < FG_WIDTH) && (fy < FG_HEIGHT)
               && (x >= clip_left) && (x <= clip_right)
               && (y >= clip_top) && (y <= clip_bottom);
        if (blank)
        begin
            return '0;
        end
        if (mode == MODE_BG || mode == MODE_BG_ALT || !covered)
        begin
            return bg;
        end
        fg = mirror[fy * FG_WIDTH + fx];
        if (mode == MODE_CHROMA)
        begin
            return (fg == KEY_COLOR) ? bg : fg;
        end
        alpha = (opacity > 4'd8) ? 8 : int'(opacity);
        return {5'(blend_channel(int'(fg[15:11]), int'(bg[15:11]), alpha)),
                6'(blend_channel(int'(fg[10:5]), int'(bg[10:5]), alpha)),
                5'(blend_channel(int'(fg[4:0]), int'(bg[4:0]), alpha))};
    endfunction

    task automatic load_image;
        pixel_t word;
        for (int addr = 0; addr < FG_WIDTH * FG_HEIGHT; addr++)
        begin
            word = pixel_t'(random_bits(16));
            // Roughly one word in eight is transparent
            if (random_bits(3) == 0)
            begin
                word = KEY_COLOR;
            end
            mirror[addr] = word;
            wr_en        = 1'b1;
            wr_addr      = ADDR_W'(addr);
            wr_pixel     = word;
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
    endtask

    task automatic set_mapping(input logic [1:0] scale, input int off_x, input int off_y,
                               input int left, input int right, input int top,
                               input int bottom);
        fg_scale    = scale;
        fg_offset_x = scoord_t'(off_x);
        fg_offset_y = scoord_t'(off_y);
        clip_left   = coord_t'(left);
        clip_right  = coord_t'(right);
        clip_top    = coord_t'(top);
        clip_bottom = coord_t'(bottom);
    endtask

    task automatic send_pixel(input string name, input coord_t x, input coord_t y,
                              input pixel_t pix, input logic blank, input int gap);
        bg_valid = 1'b1;
        bg_x     = x;
        bg_y     = y;
        bg_pixel = pix;
        bg_blank = blank;
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_pixel.push_back(model_pixel(x, y, pix, blank));
        exp_name.push_back(name);
        @(posedge clk);
        #1;
        bg_valid = 1'b0;
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Random positions in [base, base + 2^bits) on each axis
    task automatic stream_random(input string name, input int count,
                                 input int x_base, input int x_bits,
                                 input int y_base, input int y_bits,
                                 input int blanking, input logic gaps);
        coord_t x;
        coord_t y;
        pixel_t pix;
        logic   blank;
        int     gap;
        for (int i = 0; i < count; i++)
        begin
            x     = coord_t'(x_base + int'(random_bits(x_bits)));
            y     = coord_t'(y_base + int'(random_bits(y_bits)));
            pix   = pixel_t'(random_bits(16));
            blank = (blanking == ALL_BLANK)
                 || (blanking == MIX_BLANK && random_bits(2) == 0);
            gap   = gaps ? int'(random_bits(2)) : 0;
            send_pixel(name, x, y, pix, blank, gap);
        end
    endtask

    // Controls may only change with nothing in flight
    task automatic drain;
        while (exp_pixel.size() != 0)
        begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_output;
        string  name;
        coord_t x;
        coord_t y;
        pixel_t pix;
        assert (exp_pixel.size() != 0)
        else
        begin
            $display("An output pixel came out while none was expected");
            end_with_failure();
        end
        name = exp_name.pop_front();
        x    = exp_x.pop_front();
        y    = exp_y.pop_front();
        pix  = exp_pixel.pop_front();
        assert (out_x == x) else report_mismatch(name, "out_x", 16'(x), 16'(out_x));
        assert (out_y == y) else report_mismatch(name, "out_y", 16'(y), 16'(out_y));
        assert (out_pixel == pix) else report_mismatch(name, "out_pixel", pix, out_pixel);
    endtask

    // Outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        if (!reset && out_valid)
        begin
            check_output();
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d pixels outstanding",
                     cycle_count, exp_pixel.size());
            end_with_failure();
        end
    end

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        bg_valid = 1'b0;
        bg_x     = '0;
        bg_y     = '0;
        bg_pixel = '0;
        bg_blank = 1'b0;
        mode     = MODE_BG;
        opacity  = '0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_pixel = '0;
        set_mapping(2'd0, 0, 0, 0, 2047, 0, 2047);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        load_image();

        // Pass-through in both background modes
        mode = MODE_BG;
        stream_random("bg_pass", 30, 0, 10, 0, 10, NO_BLANK, 1'b1);
        drain();
        mode = MODE_BG_ALT;
        stream_random("bg_alt_pass", 30, 0, 10, 0, 10, NO_BLANK, 1'b1);
        drain();

        // Blanking over covered positions
        mode = MODE_CHROMA;
        stream_random("blanking", 30, 0, 5, 0, 4, ALL_BLANK, 1'b1);
        drain();

        // Image placed at (40, 20) with positions straddling its edges
        set_mapping(2'd0, 40, 20, 0, 2047, 0, 2047);
        stream_random("chroma_scale0", 120, 30, 6, 12, 5, NO_BLANK, 1'b1);
        drain();

        mode = MODE_BLEND;
        set_mapping(2'd0, 0, 0, 0, 2047, 0, 2047);
        foreach (exp_opacity_list[i])
        begin
            opacity = exp_opacity_list[i];
            stream_random($sformatf("blend_opacity_%0d", exp_opacity_list[i]),
                          40, 0, 6, 0, 5, NO_BLANK, 1'b1);
            drain();
        end

        // Downscaled image with a clip window and a negative x offset
        mode = MODE_CHROMA;
        set_mapping(2'd1, -8, 4, 10, 40, 6, 28);
        stream_random("scale1_clip", 80, 0, 6, 0, 6, NO_BLANK, 1'b1);
        drain();
        set_mapping(2'd2, 100, 50, 120, 200, 60, 100);
        stream_random("scale2_clip", 80, 90, 7, 40, 6, NO_BLANK, 1'b1);
        drain();

        // Strobes on every cycle with blanking mixed in
        mode    = MODE_BLEND;
        opacity = 4'd5;
        set_mapping(2'd0, 0, 0, 0, 2047, 0, 2047);
        stream_random("back_to_back", 100, 0, 6, 0, 5, MIX_BLANK, 1'b0);
        drain();

        if (exp_pixel.size() == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("%0d expected pixels never came out", exp_pixel.size());
            end_with_failure();
        end
    end

endmodule

// File: build.f
rtl/overlay_pkg.sv
rtl/fg_request.sv
rtl/fg_store.sv
rtl/chroma_key.sv
rtl/alpha_blend.sv
rtl/overlay_pipeline.sv
rtl/overlay_top.sv
test/overlay_asserts.sv
test/overlay_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the overlay testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module overlay_tb -o overlay_sim &&
./obj_dir/overlay_sim ||
exit 1
